// File: common/soc_pkg.sv
// SoC bus definitions
package soc_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// Address map, region width in byte address bits
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h0201_0000;
	localparam int MEM_AW = 10;
	localparam int MEM_DEPTH = 256;
	localparam logic [ADDR_W-1:0] CONFIG_BASE = 32'h0200_0400;
	localparam int CONFIG_AW = 4;
	localparam logic [ADDR_W-1:0] PAD_BASE = 32'h0200_0200;
	localparam int PAD_AW = 2;
	localparam logic [ADDR_W-1:0] COUNTER_BASE = 32'h0200_0300;
	localparam int COUNTER_AW = 3;

	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;
	localparam logic [1:0] RESP_DECERR = 2'd3;

	localparam int POLL_DIV_BITS = 8;
	localparam int PAD_BITS = 8;
	localparam int SLAVE_COUNT = 4;

	typedef enum logic [1:0] {
		SLV_MEM,
		SLV_CONFIG,
		SLV_PAD,
		SLV_COUNTER
	} slave_e;

	typedef struct packed {
		logic valid;
		logic write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} bus_req_t;

	typedef struct packed {
		logic valid;
		logic [1:0] resp;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef union packed {
		logic [63:0] value;
		struct packed {
			logic [DATA_W-1:0] hi;
			logic [DATA_W-1:0] lo;
		} words;
	} counter_value_u;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [15:0] reserved;
			logic [PAD_BITS-1:0] pad1;
			logic [PAD_BITS-1:0] pad0;
		} pads;
	} pad_report_u;

endpackage

// File: interconnect/bus_decoder.sv
// Address decoder and response mux
`timescale 1ns/1ns
module bus_decoder (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t bus_req,
	output soc_pkg::bus_rsp_t bus_rsp,
	output soc_pkg::bus_req_t slave_req [soc_pkg::SLAVE_COUNT],
	input soc_pkg::bus_rsp_t slave_rsp [soc_pkg::SLAVE_COUNT]
);
	import soc_pkg::*;

	logic [SLAVE_COUNT-1:0] hit;
	logic [SLAVE_COUNT-1:0] slave_valid;
	slave_e sel;
	slave_e sel_q;
	logic decerr_q;

	// Region match on the bits above each region width
	assign hit[SLV_MEM] = bus_req.addr[ADDR_W-1:MEM_AW] == MEM_BASE[ADDR_W-1:MEM_AW];
	assign hit[SLV_CONFIG] = bus_req.addr[ADDR_W-1:CONFIG_AW] == CONFIG_BASE[ADDR_W-1:CONFIG_AW];
	assign hit[SLV_PAD] = bus_req.addr[ADDR_W-1:PAD_AW] == PAD_BASE[ADDR_W-1:PAD_AW];
	assign hit[SLV_COUNTER] =
		bus_req.addr[ADDR_W-1:COUNTER_AW] == COUNTER_BASE[ADDR_W-1:COUNTER_AW];

	always_comb begin
		sel = SLV_MEM;
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			if (hit[i])
				sel = slave_e'(i);
		end
	end

	// Same request to every slave, valid only where it hits
	always_comb begin
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			slave_req[i] = bus_req;
			slave_req[i].valid = bus_req.valid && hit[i];
			slave_valid[i] = slave_req[i].valid;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			sel_q <= SLV_MEM;
			decerr_q <= 1'b0;
		end else begin
			if (bus_req.valid)
				sel_q <= sel;
			decerr_q <= bus_req.valid && !(|hit);
		end
	end

	// Slaves answer one cycle later, so the stored target picks the answer
	always_comb begin
		if (decerr_q) begin
			bus_rsp.valid = 1'b1;
			bus_rsp.resp = RESP_DECERR;
			bus_rsp.rdata = '0;
		end else begin
			bus_rsp = slave_rsp[sel_q];
		end
	end

	a_one_slave: assert property (
		@(posedge clk_50mhz) disable iff (!resetn) $onehot0(slave_valid)
	);

	a_rsp_follows: assert property (
		@(posedge clk_50mhz) disable iff (!resetn) bus_req.valid |=> bus_rsp.valid
	);

endmodule

// File: memory/scratch_memory.sv
// Scratch word memory
`timescale 1ns/1ns
module scratch_memory (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [$clog2(MEM_DEPTH)-1:0] index;
	logic valid_q;
	logic [DATA_W-1:0] rdata_q;

	// Word index, byte offset dropped
	assign index = req.addr[MEM_AW-1:2];

	always_ff @(posedge clk_50mhz) begin
		if (req.valid && req.write) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req.wstrb[b])
					mem[index][b*8 +: 8] <= req.wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (req.valid)
			rdata_q <= req.write ? '0 : mem[index];
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			valid_q <= 1'b0;
		else
			valid_q <= req.valid;
	end

	assign rsp.valid = valid_q;
	assign rsp.resp = RESP_OKAY;
	assign rsp.rdata = rdata_q;

endmodule

// File: source/config_regs.sv
// Configuration registers
`timescale 1ns/1ns
module config_regs (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp,
	output logic rotate_video
);
	import soc_pkg::*;

	logic [DATA_W-1:0] regs [2**(CONFIG_AW-2)];
	logic [CONFIG_AW-3:0] index;
	logic valid_q;
	logic [DATA_W-1:0] rdata_q;

	assign index = req.addr[CONFIG_AW-1:2];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			for (int w = 0; w < 2**(CONFIG_AW-2); w++)
				regs[w] <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= req.valid;
			if (req.valid && req.write) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (req.wstrb[b])
						regs[index][b*8 +: 8] <= req.wdata[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (req.valid)
			rdata_q <= req.write ? '0 : regs[index];
	end

	assign rsp = '{valid: valid_q, resp: RESP_OKAY, rdata: rdata_q};
	assign rotate_video = regs[0][0];

endmodule

// File: source/system_counter.sv
// 64-bit system counter
`timescale 1ns/1ns
module system_counter (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp
);
	import soc_pkg::*;

	counter_value_u count;
	logic [DATA_W-1:0] hi_hold;
	logic hi_sel;
	logic valid_q;
	logic [1:0] resp_q;
	logic [DATA_W-1:0] rdata_q;

	assign hi_sel = req.addr[COUNTER_AW-1:2];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= '0;
			hi_hold <= '0;
			valid_q <= 1'b0;
		end else begin
			count.value <= count.value + 1'b1;
			valid_q <= req.valid;
			// Low word read freezes the high word for the next read
			if (req.valid && !req.write && !hi_sel)
				hi_hold <= count.words.hi;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (req.valid) begin
			resp_q <= req.write ? RESP_SLVERR : RESP_OKAY;
			rdata_q <= req.write ? '0 : (hi_sel ? hi_hold : count.words.lo);
		end
	end

	assign rsp = '{valid: valid_q, resp: resp_q, rdata: rdata_q};

endmodule

// File: controller/pad_reader.sv
// Serial gamepad reader
`timescale 1ns/1ns
module pad_reader (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp,
	input logic pad_data0,
	input logic pad_data1,
	output logic pad_clk,
	output logic pad_latch
);
	import soc_pkg::*;

	logic [POLL_DIV_BITS-1:0] div_q;
	logic tick;
	logic [$clog2(2*PAD_BITS)-1:0] step_q;
	logic [1:0] data_in;
	logic [PAD_BITS-1:0] shift_q [2];
	logic [PAD_BITS-1:0] shift_next [2];
	pad_report_u report_q;
	logic valid_q;
	logic [1:0] resp_q;
	logic [DATA_W-1:0] rdata_q;

	assign tick = &div_q;
	assign data_in = {pad_data1, pad_data0};

	// Bit 0 arrives first, pressed buttons pull the line low
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			shift_next[p] = {~data_in[p], shift_q[p][PAD_BITS-1:1]};
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (tick && step_q[0]) begin
			for (int p = 0; p < 2; p++)
				shift_q[p] <= shift_next[p];
		end
	end

	// Step 0 latches, then odd steps drop the clock and sample
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_q <= '0;
			step_q <= '0;
			pad_latch <= 1'b0;
			pad_clk <= 1'b0;
			report_q <= '0;
			valid_q <= 1'b0;
		end else begin
			div_q <= div_q + 1'b1;
			valid_q <= req.valid;
			if (tick) begin
				step_q <= step_q + 1'b1;
				pad_latch <= step_q == '0;
				pad_clk <= !step_q[0] && step_q != '0;
				if (&step_q) begin
					report_q.pads.pad0 <= shift_next[0];
					report_q.pads.pad1 <= shift_next[1];
				end
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (req.valid) begin
			resp_q <= req.write ? RESP_SLVERR : RESP_OKAY;
			rdata_q <= req.write ? '0 : report_q.raw;
		end
	end

	assign rsp = '{valid: valid_q, resp: resp_q, rdata: rdata_q};

	a_clk_latch: assert property (
		@(posedge clk_50mhz) disable iff (!resetn) !(pad_clk && pad_latch)
	);

endmodule

// File: source/soc_top.sv
// SoC bus top level
`timescale 1ns/1ns
module soc_top (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::bus_req_t bus_req,
	output soc_pkg::bus_rsp_t bus_rsp,
	input logic pad_data0,
	input logic pad_data1,
	output logic pad_clk,
	output logic pad_latch,
	output logic rotate_video
);
	import soc_pkg::*;

	bus_req_t slave_req [SLAVE_COUNT];
	bus_rsp_t slave_rsp [SLAVE_COUNT];

	bus_decoder i_decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.slave_req(slave_req),
		.slave_rsp(slave_rsp)
	);

	scratch_memory i_memory (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(slave_req[SLV_MEM]),
		.rsp(slave_rsp[SLV_MEM])
	);

	config_regs i_config (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(slave_req[SLV_CONFIG]),
		.rsp(slave_rsp[SLV_CONFIG]),
		.rotate_video(rotate_video)
	);

	system_counter i_counter (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(slave_req[SLV_COUNTER]),
		.rsp(slave_rsp[SLV_COUNTER])
	);

	pad_reader i_pads (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(slave_req[SLV_PAD]),
		.rsp(slave_rsp[SLV_PAD]),
		.pad_data0(pad_data0),
		.pad_data1(pad_data1),
		.pad_clk(pad_clk),
		.pad_latch(pad_latch)
	);

endmodule

// File: testbench/tb_clock.sv
// Clock and reset source
`timescale 1ns/1ns
module tb_clock (
	output logic clk_50mhz,
	output logic resetn
);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	// Held low for four rising edges
	initial begin
		resetn = 1'b0;
		repeat (4) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		resetn = 1'b1;
	end

endmodule

// File: testbench/pad_model.sv
// Serial gamepad model
`timescale 1ns/1ns
module pad_model (
	input logic pad_latch,
	input logic pad_clk,
	input logic [soc_pkg::PAD_BITS-1:0] buttons,
	output logic data
);

	logic [soc_pkg::PAD_BITS-1:0] shift_q;

	initial begin
		shift_q = '0;
	end

	// Latch loads all buttons, each clock rise moves on by one
	always @(posedge pad_latch or posedge pad_clk) begin
		if (pad_latch)
			shift_q <= buttons;
		else
			shift_q <= shift_q >> 1;
	end

	// Line idles high, a pressed button pulls it low
	assign data = ~shift_q[0];

endmodule

// File: testbench/tb_soc.sv
// SoC bus testbench
`timescale 1ns/1ns
module tb_soc;
	import soc_pkg::*;

	// One poll is 16 ticks of the divided clock
	localparam int POLL_CYCLES = 2 * PAD_BITS * (2 ** POLL_DIV_BITS);
	localparam int RUN_CYCLES = 3 * MEM_DEPTH + 2 * POLL_CYCLES + 200;
	localparam int LIMIT = 2 * RUN_CYCLES;

	logic clk_50mhz;
	logic resetn;
	logic pad_data0;
	logic pad_data1;
	logic pad_clk;
	logic pad_latch;
	logic rotate_video;
	logic [PAD_BITS-1:0] buttons [2];
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	bus_rsp_t pend_rsp;
	bus_rsp_t last_rsp;
	bit pending;
	bit pend_full;
	logic [31:0] rand_state = 32'd16403;
	logic [DATA_W-1:0] mem_model [MEM_DEPTH];
	logic [DATA_W-1:0] cfg_model [4];
	logic [63:0] count_model;
	int errors;
	int checks;
	int cycles;

	tb_clock i_clock (.clk_50mhz(clk_50mhz), .resetn(resetn));
	pad_model i_pad0 (.pad_latch(pad_latch), .pad_clk(pad_clk), .buttons(buttons[0]),
		.data(pad_data0));
	pad_model i_pad1 (.pad_latch(pad_latch), .pad_clk(pad_clk), .buttons(buttons[1]),
		.data(pad_data1));

	soc_top i_dut (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.pad_data0(pad_data0),
		.pad_data1(pad_data1),
		.pad_clk(pad_clk),
		.pad_latch(pad_latch),
		.rotate_video(rotate_video)
	);

	// Counter model, zero in reset and one count per clock after it
	always @(posedge clk_50mhz) begin
		if (!resetn)
			count_model <= '0;
		else
			count_model <= count_model + 1'b1;
	end

	function automatic logic [31:0] lcg_step();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// Upper halves only since the low LCG bits repeat quickly
	function automatic logic [31:0] random_word();
		logic [31:0] a;
		logic [31:0] b;
		a = lcg_step();
		b = lcg_step();
		return {a[31:16], b[31:16]};
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] r;
		r = old;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b])
				r[b*8 +: 8] = data[b*8 +: 8];
		end
		return r;
	endfunction

	function automatic bit is_mapped(input logic [ADDR_W-1:0] a);
		return (a >> MEM_AW) == (MEM_BASE >> MEM_AW) ||
			(a >> CONFIG_AW) == (CONFIG_BASE >> CONFIG_AW) ||
			(a >> PAD_AW) == (PAD_BASE >> PAD_AW) ||
			(a >> COUNTER_AW) == (COUNTER_BASE >> COUNTER_AW);
	endfunction

	task automatic flag_check(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic word_check(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic response_check(input bus_rsp_t got, input bus_rsp_t want, input bit full);
		checks++;
		if (got.valid !== want.valid || got.resp !== want.resp ||
			(full && got.rdata !== want.rdata)) begin
			errors++;
			$display("ERROR bus_rsp got %h expected %h", got, want);
		end
	endtask

	task automatic report_check(input pad_report_u got, input pad_report_u want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR pad report got %h expected %h", got.raw, want.raw);
		end
	endtask

	// Answer to the previous request is due exactly now
	task automatic drive_cycle(input bus_req_t req, input bus_rsp_t want, input bit full);
		@(negedge clk_50mhz);
		last_rsp = bus_rsp;
		if (pending)
			response_check(bus_rsp, pend_rsp, pend_full);
		else
			flag_check("bus_rsp.valid", bus_rsp.valid, 1'b0);
		bus_req = req;
		pending = req.valid;
		pend_rsp = want;
		pend_full = full;
	endtask

	task automatic idle_cycle();
		drive_cycle('0, '0, 1'b0);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] where, input logic [1:0] resp,
		input logic [DATA_W-1:0] data, input bit full);
		drive_cycle('{valid: 1'b1, write: 1'b0, addr: where, wdata: '0, wstrb: '0},
			'{valid: 1'b1, resp: resp, rdata: data}, full);
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] where, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, input logic [1:0] resp);
		drive_cycle('{valid: 1'b1, write: 1'b1, addr: where, wdata: data, wstrb: strb},
			'{valid: 1'b1, resp: resp, rdata: '0}, resp != RESP_SLVERR);
	endtask

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk_50mhz);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [DATA_W-1:0] data;
		logic [ADDR_W-1:0] addr;
		logic [$clog2(MEM_DEPTH)-1:0] idx;
		logic [DATA_W-1:0] first;
		logic [DATA_W-1:0] second;
		int n;
		pad_report_u want_report;

		bus_req = '0;
		buttons[0] = '0;
		buttons[1] = '0;
		pending = 1'b0;
		pend_rsp = '0;
		pend_full = 1'b0;
		errors = 0;
		checks = 0;
		for (int w = 0; w < 4; w++)
			cfg_model[w] = '0;
		wait (resetn);
		flag_check("pad_latch", pad_latch, 1'b0);
		flag_check("pad_clk", pad_clk, 1'b0);
		flag_check("rotate_video", rotate_video, 1'b0);

		// Whole memory first so that no read sees an unwritten word
		for (int i = 0; i < MEM_DEPTH; i++) begin
			mem_model[i] = random_word();
			write_word(MEM_BASE + 4 * i, mem_model[i], '1, RESP_OKAY);
		end
		for (int i = 0; i < 200; i++) begin
			r = random_word();
			data = random_word();
			idx = r[15:8];
			mem_model[idx] = merge_bytes(mem_model[idx], data, r[7:4]);
			write_word(MEM_BASE + 4 * idx + r[1:0], data, r[7:4], RESP_OKAY);
		end
		for (int i = 0; i < MEM_DEPTH; i++) begin
			r = random_word();
			idx = r[15:8];
			read_word(MEM_BASE + 4 * idx + r[1:0], RESP_OKAY, mem_model[idx], 1'b1);
		end
		idle_cycle();

		for (int i = 0; i < 8; i++) begin
			r = random_word();
			data = random_word();
			cfg_model[r[1:0]] = merge_bytes(cfg_model[r[1:0]], data, r[7:4]);
			write_word(CONFIG_BASE + 4 * r[1:0], data, r[7:4], RESP_OKAY);
			idle_cycle();
			flag_check("rotate_video", rotate_video, cfg_model[0][0]);
		end
		for (int w = 0; w < 4; w++)
			read_word(CONFIG_BASE + 4 * w, RESP_OKAY, cfg_model[w], 1'b1);
		idle_cycle();

		r = random_word();
		buttons[0] = r[7:0];
		buttons[1] = r[15:8];
		want_report.pads.reserved = '0;
		want_report.pads.pad1 = buttons[1];
		want_report.pads.pad0 = buttons[0];
		repeat (2 * POLL_CYCLES) idle_cycle();
		read_word(PAD_BASE, RESP_OKAY, '0, 1'b0);
		idle_cycle();
		report_check(pad_report_u'(last_rsp.rdata), want_report);

		// Just past each region and then anywhere
		for (int i = 0; i < 24; i++) begin
			case (i)
				0: addr = MEM_BASE + (1 << MEM_AW);
				1: addr = CONFIG_BASE + (1 << CONFIG_AW);
				2: addr = PAD_BASE + (1 << PAD_AW);
				3: addr = COUNTER_BASE + (1 << COUNTER_AW);
				default: addr = random_word();
			endcase
			if (!is_mapped(addr)) begin
				if (addr[4])
					write_word(addr, random_word(), '1, RESP_DECERR);
				else
					read_word(addr, RESP_DECERR, '0, 1'b1);
			end
		end
		write_word(PAD_BASE, random_word(), '1, RESP_SLVERR);
		write_word(COUNTER_BASE, random_word(), '1, RESP_SLVERR);
		write_word(COUNTER_BASE + 4, random_word(), '1, RESP_SLVERR);
		read_word(PAD_BASE, RESP_OKAY, want_report.raw, 1'b1);
		idle_cycle();

		// Lo reads n cycles apart and a hi read right behind
		r = random_word();
		n = 8 + r[4:0];
		read_word(COUNTER_BASE, RESP_OKAY, '0, 1'b0);
		idle_cycle();
		first = last_rsp.rdata;
		// Response carries the count from the request edge
		word_check("counter lo", first, count_model[DATA_W-1:0] - 1'b1);
		repeat (n - 2) idle_cycle();
		read_word(COUNTER_BASE, RESP_OKAY, '0, 1'b0);
		read_word(COUNTER_BASE + 4, RESP_OKAY, '0, 1'b1);
		second = last_rsp.rdata;
		idle_cycle();
		word_check("counter lo difference", second - first, DATA_W'(n));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: soc_lite.f
common/soc_pkg.sv
interconnect/bus_decoder.sv
memory/scratch_memory.sv
source/config_regs.sv
source/system_counter.sv
controller/pad_reader.sv
source/soc_top.sv
testbench/tb_clock.sv
testbench/pad_model.sv
testbench/tb_soc.sv
